/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int num_set        = 16;
    localparam int set_bits       = 4;
    localparam int num_way        = 4;
    localparam int byte_len       = 8;
    localparam int line_bits      = 64;
    localparam int line_bytes     = 8;
    localparam int tag_bits       = 20;
    localparam int tag_bytes      = 3;
    localparam int tag_entry_bits = 24;                 // Tag padded to whole bytes

    localparam int storage_lutram   = 0;
    localparam int storage_blockram = 1;

    typedef struct packed {
        logic [set_bits-1:0] set;
        logic [tag_bits-1:0] tag;
    } lookup_req_t;

    typedef struct packed {
        logic [set_bits-1:0]   set;
        logic [num_way-1:0]    way;                     // One-hot target way
        logic [tag_bits-1:0]   tag;
        logic [line_bits-1:0]  data;
        logic [line_bytes-1:0] byte_en;
    } fill_req_t;

    typedef struct packed {
        logic                 hit;
        logic [num_way-1:0]   way;                      // Zero on a miss
        logic [line_bits-1:0] data;
    } lookup_resp_t;

endpackage

`default_nettype wire

/* single_port_lutram.sv */
`timescale 1ns/10ps
`default_nettype none

module single_port_lutram
#(
    parameter int entry_bits = cache_pkg::tag_entry_bits,
    parameter int mask_bits  = cache_pkg::tag_bytes
)
(
    input  wire logic                          clk_in,
    input  wire logic                          reset_in,
    input  wire logic                          access_en,
    input  wire logic [mask_bits-1:0]          write_en,
    input  wire logic [cache_pkg::set_bits-1:0] set_addr,
    input  wire logic [entry_bits-1:0]         write_entry,
    output logic      [entry_bits-1:0]         read_entry,
    output logic                               read_valid
);

    logic [entry_bits-1:0]         mem [cache_pkg::num_set];
    logic [entry_bits-1:0]         read_word;
    logic [cache_pkg::num_set-1:0] valid_bits;

    assign read_word = mem[set_addr];                   // Distributed read path

    always_ff @(posedge clk_in)
    begin
        if (access_en)
        begin
            for (int i = 0; i < mask_bits; i++)
            begin
                if (write_en[i])
                    mem[set_addr][i*cache_pkg::byte_len +: cache_pkg::byte_len] <=
                        write_entry[i*cache_pkg::byte_len +: cache_pkg::byte_len];
            end
            read_entry <= read_word;                    // Old contents on a write
        end
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            valid_bits <= '0;
            read_valid <= 1'b0;
        end
        else if (access_en)
        begin
            if (|write_en)
                valid_bits[set_addr] <= 1'b1;
            read_valid <= valid_bits[set_addr];
        end
    end

endmodule

`default_nettype wire

/* single_port_blockram.sv */
`timescale 1ns/10ps
`default_nettype none

module single_port_blockram
#(
    parameter int entry_bits = cache_pkg::line_bits,
    parameter int mask_bits  = cache_pkg::line_bytes
)
(
    input  wire logic                          clk_in,
    input  wire logic                          reset_in,
    input  wire logic                          access_en,
    input  wire logic [mask_bits-1:0]          write_en,
    input  wire logic [cache_pkg::set_bits-1:0] set_addr,
    input  wire logic [entry_bits-1:0]         write_entry,
    output logic      [entry_bits-1:0]         read_entry,
    output logic                               read_valid
);

    logic [entry_bits-1:0]         mem [cache_pkg::num_set];
    logic [cache_pkg::num_set-1:0] valid_bits;

    // Read-first port with byte lanes that maps to block memory
    always_ff @(posedge clk_in)
    begin
        if (access_en)
        begin
            for (int i = 0; i < mask_bits; i++)
            begin
                if (write_en[i])
                    mem[set_addr][i*cache_pkg::byte_len +: cache_pkg::byte_len] <=
                        write_entry[i*cache_pkg::byte_len +: cache_pkg::byte_len];
            end
            read_entry <= mem[set_addr];
        end
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            valid_bits <= '0;
            read_valid <= 1'b0;
        end
        else if (access_en)
        begin
            if (|write_en)
                valid_bits[set_addr] <= 1'b1;           // Any write marks the set
            read_valid <= valid_bits[set_addr];
        end
    end

endmodule

`default_nettype wire

/* mux_decoded.sv */
`timescale 1ns/10ps
`default_nettype none

module mux_decoded
#(
    parameter int entry_bits = cache_pkg::line_bits
)
(
    input  wire logic [cache_pkg::num_way*entry_bits-1:0] ways_flat,
    input  wire logic [cache_pkg::num_way-1:0]            sel,
    output logic      [entry_bits-1:0]                    entry
);

    // AND-OR select gives zero for an all-zero select
    always_comb
    begin
        entry = '0;
        for (int w = 0; w < cache_pkg::num_way; w++)
        begin
            entry = entry | (ways_flat[w*entry_bits +: entry_bits] & {entry_bits{sel[w]}});
        end
    end

endmodule

`default_nettype wire

/* associative_single_port_array.sv */
`timescale 1ns/10ps
`default_nettype none

module associative_single_port_array
#(
    parameter  int storage_type = cache_pkg::storage_lutram,
    localparam int entry_bits   = (storage_type == cache_pkg::storage_lutram) ?
                                  cache_pkg::tag_entry_bits : cache_pkg::line_bits,
    localparam int mask_bits    = (storage_type == cache_pkg::storage_lutram) ?
                                  cache_pkg::tag_bytes : cache_pkg::line_bytes
)
(
    input  wire logic                                     clk_in,
    input  wire logic                                     reset_in,
    input  wire logic                                     access_en,
    input  wire logic [mask_bits-1:0]                     write_en,
    input  wire logic [cache_pkg::set_bits-1:0]           set_addr,
    input  wire logic [cache_pkg::num_way-1:0]            way_select,
    input  wire logic [entry_bits-1:0]                    write_entry,
    output logic      [cache_pkg::num_way*entry_bits-1:0] read_set,
    output logic      [cache_pkg::num_way-1:0]            read_valid_set,
    output logic      [entry_bits-1:0]                    read_entry
);

    logic [cache_pkg::num_way-1:0] way_select_q;

    for (genvar w = 0; w < cache_pkg::num_way; w++)
    begin : g_way
        if (storage_type == cache_pkg::storage_lutram)
        begin : g_lutram
            single_port_lutram
            #(
                .entry_bits  (entry_bits),
                .mask_bits   (mask_bits)
            )
            u_way
            (
                .clk_in      (clk_in),
                .reset_in    (reset_in),
                .access_en   (access_en & way_select[w]),
                .write_en    (write_en & {mask_bits{way_select[w]}}),
                .set_addr    (set_addr),
                .write_entry (write_entry),
                .read_entry  (read_set[w*entry_bits +: entry_bits]),
                .read_valid  (read_valid_set[w])
            );
        end
        else
        begin : g_blockram
            single_port_blockram
            #(
                .entry_bits  (entry_bits),
                .mask_bits   (mask_bits)
            )
            u_way
            (
                .clk_in      (clk_in),
                .reset_in    (reset_in),
                .access_en   (access_en & way_select[w]),
                .write_en    (write_en & {mask_bits{way_select[w]}}),
                .set_addr    (set_addr),
                .write_entry (write_entry),
                .read_entry  (read_set[w*entry_bits +: entry_bits]),
                .read_valid  (read_valid_set[w])
            );
        end
    end

    // Select follows the data by one cycle
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
            way_select_q <= '0;
        else
            way_select_q <= way_select;
    end

    mux_decoded
    #(
        .entry_bits (entry_bits)
    )
    u_mux
    (
        .ways_flat  (read_set),
        .sel        (way_select_q),
        .entry      (read_entry)
    );

endmodule

`default_nettype wire

/* tag_match.sv */
`timescale 1ns/10ps
`default_nettype none

module tag_match
(
    input  wire logic [cache_pkg::num_way*cache_pkg::tag_entry_bits-1:0] tags_flat,
    input  wire logic [cache_pkg::num_way-1:0]                           valid_set,
    input  wire logic [cache_pkg::tag_bits-1:0]                          tag,
    output logic      [cache_pkg::num_way-1:0]                           hit_way
);

    logic [cache_pkg::tag_entry_bits-1:0] stored;

    always_comb
    begin
        stored  = '0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::num_way; w++)
        begin
            stored = tags_flat[w*cache_pkg::tag_entry_bits +: cache_pkg::tag_entry_bits];
            // Padding bits above the tag are ignored
            hit_way[w] = valid_set[w] && (stored[cache_pkg::tag_bits-1:0] == tag);
        end
    end

endmodule

`default_nettype wire

/* cache_store.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_store
(
    input  wire logic                   clk_in,
    input  wire logic                   reset_in,
    input  wire logic                   lookup_valid,
    input  wire cache_pkg::lookup_req_t lookup,
    input  wire logic                   fill_valid,
    input  wire cache_pkg::fill_req_t   fill,
    output logic                        resp_valid,
    output cache_pkg::lookup_resp_t     resp
);

    logic                                tag_access;
    logic [cache_pkg::set_bits-1:0]      tag_set;
    logic [cache_pkg::num_way-1:0]       tag_way_sel;
    logic [cache_pkg::tag_entry_bits-1:0] tag_padded;
    logic [cache_pkg::num_way*cache_pkg::tag_entry_bits-1:0] tags_flat;
    logic [cache_pkg::num_way-1:0]       tag_valid_set;

    logic                                lookup_s1;
    cache_pkg::lookup_req_t              lookup_q;
    logic                                fill_s1;
    cache_pkg::fill_req_t                fill_q;
    logic [cache_pkg::num_way-1:0]       hit_way;

    logic [cache_pkg::set_bits-1:0]      data_set;
    logic [cache_pkg::num_way-1:0]       data_way_sel;
    logic [cache_pkg::line_bytes-1:0]    data_write_en;
    logic [cache_pkg::line_bits-1:0]     data_line;
    logic [cache_pkg::num_way-1:0]       hit_q;

    // In stage 0 a fill wins over a lookup in the same cycle
    assign tag_access  = lookup_valid | fill_valid;
    assign tag_set     = fill_valid ? fill.set : lookup.set;
    assign tag_way_sel = fill_valid ? fill.way : '1;
    assign tag_padded  = {{(cache_pkg::tag_entry_bits-cache_pkg::tag_bits){1'b0}}, fill.tag};

    associative_single_port_array
    #(
        .storage_type   (cache_pkg::storage_lutram)
    )
    tag_array
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .access_en      (tag_access),
        .write_en       ({cache_pkg::tag_bytes{fill_valid}}),
        .set_addr       (tag_set),
        .way_select     (tag_way_sel),
        .write_entry    (tag_padded),
        .read_set       (tags_flat),
        .read_valid_set (tag_valid_set),
        .read_entry     ()
    );

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            lookup_s1 <= 1'b0;
            lookup_q  <= '0;
            fill_s1   <= 1'b0;
            fill_q    <= '0;
        end
        else
        begin
            lookup_s1 <= lookup_valid & ~fill_valid;
            lookup_q  <= lookup;
            fill_s1   <= fill_valid;
            fill_q    <= fill;
        end
    end

    tag_match u_tag_match
    (
        .tags_flat (tags_flat),
        .valid_set (tag_valid_set),
        .tag       (lookup_q.tag),
        .hit_way   (hit_way)
    );

    // In stage 1 the data array serves either the staged fill or the lookup hit
    assign data_set      = fill_s1 ? fill_q.set : lookup_q.set;
    assign data_way_sel  = fill_s1 ? fill_q.way : (lookup_s1 ? hit_way : '0);
    assign data_write_en = fill_s1 ? fill_q.byte_en : '0;

    associative_single_port_array
    #(
        .storage_type   (cache_pkg::storage_blockram)
    )
    data_array
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .access_en      (fill_s1 | lookup_s1),
        .write_en       (data_write_en),
        .set_addr       (data_set),
        .way_select     (data_way_sel),
        .write_entry    (fill_q.data),
        .read_set       (),
        .read_valid_set (),
        .read_entry     (data_line)
    );

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            resp_valid <= 1'b0;
            hit_q      <= '0;
        end
        else
        begin
            resp_valid <= lookup_s1;
            hit_q      <= lookup_s1 ? hit_way : '0;
        end
    end

    // Stage 2 data is already zero on a miss
    always_comb
    begin
        resp.hit  = |hit_q;
        resp.way  = hit_q;
        resp.data = data_line;
    end

endmodule

`default_nettype wire

/* cache_store_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_store_tb;

    typedef struct packed {
        logic [31:0]             due;               // Negedge count when resp_valid is expected
        cache_pkg::lookup_resp_t resp;
    } expect_t;

    logic                    clk_in;
    logic                    reset_in;
    logic                    lookup_valid;
    cache_pkg::lookup_req_t  lookup;
    logic                    fill_valid;
    cache_pkg::fill_req_t    fill;
    logic                    resp_valid;
    cache_pkg::lookup_resp_t resp;

    integer      seed = 72;
    logic [31:0] neg_cycle = 0;
    expect_t     expect_q [$];
    expect_t     exp_front;
    logic        resp_due;
    int          drain_wait;

    logic [cache_pkg::tag_bits-1:0]  m_tag   [cache_pkg::num_set][cache_pkg::num_way];
    logic                            m_valid [cache_pkg::num_set][cache_pkg::num_way];
    logic [cache_pkg::line_bits-1:0] m_data  [cache_pkg::num_set][cache_pkg::num_way];

    logic [cache_pkg::tag_bits-1:0] tag_pool [6] =
        '{20'h0a5c3, 20'h13377, 20'hfff00, 20'h00001, 20'h5a5a5, 20'h80808};

    cache_store cache_store_i
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .fill_valid   (fill_valid),
        .fill         (fill),
        .resp_valid   (resp_valid),
        .resp         (resp)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk_in);
            lookup_valid <= 1'b0;
            fill_valid   <= 1'b0;
        end
    endtask

    task automatic issue_lookup(input logic [3:0] set, input logic [19:0] tag);
        expect_t                e;
        cache_pkg::lookup_req_t req;
        e = '0;
        req.set = set;
        req.tag = tag;
        for (int w = 0; w < cache_pkg::num_way; w++)
        begin
            if (m_valid[set][w] && m_tag[set][w] == tag)
            begin
                e.resp.hit    = 1'b1;
                e.resp.way[w] = 1'b1;
                e.resp.data   = m_data[set][w];
            end
        end
        @(posedge clk_in);
        e.due = neg_cycle + 2;                      // Fixed two-cycle latency
        expect_q.push_back(e);
        lookup_valid <= 1'b1;
        lookup       <= req;
        fill_valid   <= 1'b0;
    endtask

    task automatic issue_fill(input logic [3:0] set, input logic [3:0] way, input logic [19:0] tag,
                              input logic [63:0] data, input logic [7:0] byte_en);
        cache_pkg::fill_req_t req;
        int                   target;
        target = 0;
        for (int w = 0; w < cache_pkg::num_way; w++)
        begin
            if (way[w])
                target = w;
        end
        for (int w = 0; w < cache_pkg::num_way; w++)
        begin
            if (m_valid[set][w] && m_tag[set][w] == tag)
                target = w;                         // Keep a tag in one way only
        end
        if (!m_valid[set][target])
            byte_en = '1;                           // First write of a line is whole
        for (int b = 0; b < cache_pkg::line_bytes; b++)
        begin
            if (byte_en[b])
                m_data[set][target][b*8 +: 8] = data[b*8 +: 8];
        end
        m_tag[set][target]   = tag;
        m_valid[set][target] = 1'b1;
        req = '{set: set, way: 4'b0001 << target, tag: tag, data: data, byte_en: byte_en};
        @(posedge clk_in);
        fill_valid   <= 1'b1;
        fill         <= req;
        lookup_valid <= (rand_below(4) == 0);      // A lookup beside a fill gets no response
    endtask

    // Response monitor checks response count and contents
    always @(negedge clk_in)
    begin
        if (!reset_in)
        begin
            resp_due = (expect_q.size() != 0) && (expect_q[0].due == neg_cycle);
            check_value("resp_valid", resp_valid, resp_due);
            if (resp_valid)
            begin
                exp_front = expect_q.pop_front();
                check_value("resp.hit", resp.hit, exp_front.resp.hit);
                check_value("resp.way", resp.way, exp_front.resp.way);
                check_value("resp.data", resp.data, exp_front.resp.data);
            end
        end
        neg_cycle = neg_cycle + 1;
    end

    initial
    begin
        reset_in     = 1'b1;
        lookup_valid = 1'b0;
        lookup       = '0;
        fill_valid   = 1'b0;
        fill         = '0;
        for (int s = 0; s < cache_pkg::num_set; s++)
            for (int w = 0; w < cache_pkg::num_way; w++)
                m_valid[s][w] = 1'b0;
        repeat (8) @(posedge clk_in);
        reset_in <= 1'b0;

        idle(5);                                    // No requests and no responses
        for (int s = 0; s < cache_pkg::num_set; s++)
            issue_lookup(s, tag_pool[rand_below(6)]);
        idle(3);

        issue_fill(4'd1, 4'b0100, tag_pool[0], {$random(seed), $random(seed)}, 8'hff);
        idle(3);
        issue_lookup(4'd1, tag_pool[0]);
        idle(3);

        for (int i = 0; i < 8; i++)
        begin
            issue_fill(4'd1, 4'b0100, tag_pool[0], {$random(seed), $random(seed)}, $random(seed));
            idle(1);
            issue_lookup(4'd1, tag_pool[0]);
        end

        // Lookup in the cycle right after a fill
        issue_fill(4'd2, 4'b0010, tag_pool[3], {$random(seed), $random(seed)}, 8'hff);
        issue_lookup(4'd2, tag_pool[3]);
        issue_fill(4'd2, 4'b0010, tag_pool[3], {$random(seed), $random(seed)}, 8'h3c);
        issue_lookup(4'd2, tag_pool[3]);

        // Tag held by set 5 only
        issue_fill(4'd5, 4'b0001, tag_pool[4], {$random(seed), $random(seed)}, 8'hff);
        idle(2);
        issue_lookup(4'd6, tag_pool[4]);
        issue_lookup(4'd5, tag_pool[1]);
        issue_lookup(4'd5, tag_pool[4]);
        idle(3);

        repeat (300)
        begin
            case (rand_below(8))
                0, 1:    issue_fill(rand_below(16), 4'b0001 << rand_below(4),
                                    tag_pool[rand_below(6)], {$random(seed), $random(seed)},
                                    $random(seed));
                7:       idle(1);
                default: issue_lookup(rand_below(16), tag_pool[rand_below(6)]);
            endcase
        end
        idle(1);

        drain_wait = 0;
        while (expect_q.size() != 0 && drain_wait < 20)
        begin
            @(posedge clk_in);
            drain_wait++;
        end
        if (expect_q.size() != 0)
        begin
            $display("Responses stopped arriving with %0d lookups unanswered", expect_q.size());
            $display("Testbench failed");
            $fatal(1);
        end
        else
        begin
            idle(4);                                // Catch any extra response
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
cache_pkg.sv
single_port_lutram.sv
single_port_blockram.sv
mux_decoded.sv
associative_single_port_array.sv
tag_match.sv
cache_store.sv
cache_store_tb.sv
